// ==== rtl/sdhc_pkg.sv ====
/* shared constants for the SD command-line host; sizes follow the SD command format
   CMD word layout: index in bits 5..0, response type in bits 9..8 */
package sdhc_pkg;

  // command path sizing
  localparam int CmdQueueDepth   = 2;
  localparam int FrameBits       = 48;
  localparam int RespTimeoutClks = 64;
  localparam int DebounceCycles  = 16;

  // bits before the crc field, and the end bit position
  localparam int CrcStartBit = 40;
  localparam int EndBitPos   = FrameBits - 1;

  localparam int CreditW   = $clog2(CmdQueueDepth + 1);
  localparam int QPtrW     = $clog2(CmdQueueDepth);
  localparam int BitCntW   = $clog2(FrameBits + 1);
  localparam int TimeoutW  = $clog2(RespTimeoutClks);
  localparam int DebounceW = $clog2(DebounceCycles);

  // register map
  localparam logic [3:0] RegArg       = 4'd0;
  localparam logic [3:0] RegCmd       = 4'd1;
  localparam logic [3:0] RegResp      = 4'd2;
  localparam logic [3:0] RegStatus    = 4'd3;
  localparam logic [3:0] RegClkDiv    = 4'd4;
  localparam logic [3:0] RegIrqEn     = 4'd5;
  localparam logic [3:0] RegSoftReset = 4'd6;

  // response types
  localparam logic [1:0] RespNone = 2'd0;
  localparam logic [1:0] RespR1   = 2'd1;
  localparam logic [1:0] RespR3   = 2'd2;

  // status bits, 0..6 are sticky
  localparam int StDone      = 0;
  localparam int StTimeout   = 1;
  localparam int StCrcErr    = 2;
  localparam int StIndexErr  = 3;
  localparam int StEndErr    = 4;
  localparam int StCardErr   = 5;
  localparam int StBusy      = 6;
  localparam int StInserted  = 7;
  localparam int StQueueFull = 8;

  // command engine states
  localparam logic [1:0] EngIdle = 2'd0;
  localparam logic [1:0] EngSend = 2'd1;
  localparam logic [1:0] EngWait = 2'd2;
  localparam logic [1:0] EngRecv = 2'd3;

  // response argument, card status or OCR
  typedef union packed {
    struct packed {
      logic [12:0] err;
      logic [5:0]  rsvd_hi;
      logic [3:0]  cur_state;
      logic        rdy_data;
      logic [7:0]  rsvd_lo;
    } r1;
    struct packed {
      logic        busy_n;
      logic [30:0] ocr;
    } r3;
  } sdhc_resp_u;

  // one serial step of crc7, x^7 + x^3 + 1
  function automatic logic [6:0] crc7_next(logic [6:0] crc, logic din);
    logic fb;
    fb = crc[6] ^ din;
    return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
  endfunction

endpackage

// ==== rtl/sdhc_card_detect.sv ====
/* sd_cd_ni is active low and asynchronous; output follows after DebounceCycles stable */
`timescale 1ns/1ns
module sdhc_card_detect
  import sdhc_pkg::*;
(
  input  logic clk_i,
  input  logic rst_i,
  input  logic sd_cd_ni,
  output logic card_inserted_o
);

  logic [1:0]           sync_q;
  logic [DebounceW-1:0] cnt_q;
  logic                 inserted_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q     <= 2'b00;
      cnt_q      <= '0;
      inserted_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], !sd_cd_ni};
      if (sync_q[1] == inserted_q) begin
        cnt_q <= '0;
      end else if (cnt_q == DebounceW'(DebounceCycles - 1)) begin
        cnt_q      <= '0;
        inserted_q <= sync_q[1];
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign card_inserted_o = inserted_q;

endmodule

// ==== rtl/sdhc_clk_gen.sv ====
/* sd_clk_o = clk_i / (2 * (clk_div_i + 1)); edge enables lead each edge by one cycle
   a new divide takes effect at the next half-period boundary */
`timescale 1ns/1ns
module sdhc_clk_gen
  import sdhc_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic [7:0] clk_div_i,
  output logic       sd_clk_o,
  output logic       sd_clk_rise_o,
  output logic       sd_clk_fall_o
);

  logic [7:0] cnt_q;
  logic [7:0] div_q;
  logic       sd_clk_q;
  logic       half_end;

  assign half_end = (cnt_q == div_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q    <= 8'd0;
      div_q    <= 8'd0;
      sd_clk_q <= 1'b0;
    end else if (half_end) begin
      cnt_q    <= 8'd0;
      // divider sampled only here
      div_q    <= clk_div_i;
      sd_clk_q <= !sd_clk_q;
    end else begin
      cnt_q <= cnt_q + 8'd1;
    end
  end

  assign sd_clk_o      = sd_clk_q;
  assign sd_clk_rise_o = half_end && !sd_clk_q;
  assign sd_clk_fall_o = half_end && sd_clk_q;

endmodule

// ==== rtl/sdhc_cmd_engine.sv ====
/* command queue, frame serializer and response receiver; no response checking here
   pushes beyond CmdQueueDepth are prevented upstream by the credit counter */
`timescale 1ns/1ns
module sdhc_cmd_engine
  import sdhc_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        soft_rst_i,
  input  logic        sd_clk_rise_i,
  input  logic        sd_clk_fall_i,
  input  logic        cmd_push_i,
  input  logic [31:0] cmd_arg_i,
  input  logic [5:0]  cmd_index_i,
  input  logic [1:0]  cmd_resp_type_i,
  output logic        cmd_credit_o,
  output logic        sd_cmd_o,
  output logic        sd_cmd_en_o,
  input  logic        sd_cmd_i,
  output logic        resp_valid_o,
  output logic        resp_timeout_o,
  output logic [1:0]  resp_type_o,
  output logic [5:0]  exp_index_o,
  output logic [5:0]  resp_index_o,
  output logic [31:0] resp_arg_o,
  output logic [6:0]  resp_crc_o,
  output logic        resp_end_o
);

  logic [31:0]          q_arg   [CmdQueueDepth];
  logic [5:0]           q_index [CmdQueueDepth];
  logic [1:0]           q_type  [CmdQueueDepth];
  logic [QPtrW-1:0]     wr_ptr_q;
  logic [QPtrW-1:0]     rd_ptr_q;
  logic [CreditW-1:0]   q_count_q;
  logic [1:0]           state_q;
  logic [BitCntW-1:0]   bit_cnt_q;
  logic [TimeoutW-1:0]  timeout_cnt_q;
  logic [39:0]          tx_sr_q;
  logic [6:0]           crc_q;
  logic [FrameBits-1:0] rx_sr_q;
  logic [5:0]           cur_index_q;
  logic [1:0]           cur_type_q;
  logic                 cmd_q;
  logic                 cmd_en_q;
  logic                 resp_valid_q;
  logic                 resp_timeout_q;
  logic                 pop;

  assign pop          = (state_q == EngIdle) && (q_count_q != '0);
  assign cmd_credit_o = pop;

  always_ff @(posedge clk_i) begin
    if (cmd_push_i) begin
      q_arg[wr_ptr_q]   <= cmd_arg_i;
      q_index[wr_ptr_q] <= cmd_index_i;
      q_type[wr_ptr_q]  <= cmd_resp_type_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || soft_rst_i) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      q_count_q <= '0;
    end else begin
      if (cmd_push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({cmd_push_i, pop})
        2'b10:   q_count_q <= q_count_q + 1'b1;
        2'b01:   q_count_q <= q_count_q - 1'b1;
        default: q_count_q <= q_count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || soft_rst_i) begin
      state_q        <= EngIdle;
      bit_cnt_q      <= '0;
      timeout_cnt_q  <= '0;
      cmd_q          <= 1'b1;
      cmd_en_q       <= 1'b0;
      resp_valid_q   <= 1'b0;
      resp_timeout_q <= 1'b0;
    end else begin
      resp_valid_q   <= 1'b0;
      resp_timeout_q <= 1'b0;
      case (state_q)
        EngIdle: begin
          if (pop) begin
            // start bit 0, direction bit 1 for host to card
            tx_sr_q     <= {1'b0, 1'b1, q_index[rd_ptr_q], q_arg[rd_ptr_q]};
            cur_index_q <= q_index[rd_ptr_q];
            cur_type_q  <= q_type[rd_ptr_q];
            crc_q       <= 7'd0;
            bit_cnt_q   <= '0;
            state_q     <= EngSend;
          end
        end
        EngSend: begin
          if (sd_clk_fall_i) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q < BitCntW'(CrcStartBit)) begin
              cmd_en_q <= 1'b1;
              cmd_q    <= tx_sr_q[39];
              tx_sr_q  <= {tx_sr_q[38:0], 1'b0};
              crc_q    <= crc7_next(crc_q, tx_sr_q[39]);
            end else if (bit_cnt_q < BitCntW'(EndBitPos)) begin
              cmd_q <= crc_q[6];
              crc_q <= {crc_q[5:0], 1'b0};
            end else if (bit_cnt_q == BitCntW'(EndBitPos)) begin
              cmd_q <= 1'b1;
            end else begin
              // end bit done, hand the line to the card
              cmd_en_q      <= 1'b0;
              timeout_cnt_q <= '0;
              if (cur_type_q == RespNone) begin
                resp_valid_q <= 1'b1;
                state_q      <= EngIdle;
              end else begin
                state_q <= EngWait;
              end
            end
          end
        end
        EngWait: begin
          if (sd_clk_rise_i) begin
            if (!sd_cmd_i) begin
              rx_sr_q   <= {rx_sr_q[FrameBits-2:0], sd_cmd_i};
              bit_cnt_q <= BitCntW'(1);
              state_q   <= EngRecv;
            end else if (timeout_cnt_q == TimeoutW'(RespTimeoutClks - 1)) begin
              resp_valid_q   <= 1'b1;
              resp_timeout_q <= 1'b1;
              state_q        <= EngIdle;
            end else begin
              timeout_cnt_q <= timeout_cnt_q + 1'b1;
            end
          end
        end
        default: begin
          if (sd_clk_rise_i) begin
            rx_sr_q   <= {rx_sr_q[FrameBits-2:0], sd_cmd_i};
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == BitCntW'(EndBitPos)) begin
              resp_valid_q <= 1'b1;
              state_q      <= EngIdle;
            end
          end
        end
      endcase
    end
  end

  assign sd_cmd_o       = cmd_q;
  assign sd_cmd_en_o    = cmd_en_q;
  assign resp_valid_o   = resp_valid_q;
  assign resp_timeout_o = resp_timeout_q;
  assign resp_type_o    = cur_type_q;
  assign exp_index_o    = cur_index_q;
  assign resp_index_o   = rx_sr_q[45:40];
  assign resp_arg_o     = rx_sr_q[39:8];
  assign resp_crc_o     = rx_sr_q[7:1];
  assign resp_end_o     = rx_sr_q[0];

endmodule

// ==== rtl/sdhc_reg_decode.sv ====
/* register port decode; reads return data one cycle after reg_valid_i
   a RegCmd write with no credit left is dropped */
`timescale 1ns/1ns
module sdhc_reg_decode
  import sdhc_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        reg_valid_i,
  input  logic        reg_write_i,
  input  logic [3:0]  reg_addr_i,
  input  logic [31:0] reg_wdata_i,
  output logic [31:0] reg_rdata_o,
  input  logic [7:0]  status_i,
  input  logic [31:0] resp_arg_i,
  output logic [6:0]  status_clr_o,
  output logic        cmd_push_o,
  output logic [31:0] cmd_arg_o,
  output logic [5:0]  cmd_index_o,
  output logic [1:0]  cmd_resp_type_o,
  input  logic        cmd_credit_i,
  output logic [7:0]  clk_div_o,
  output logic [6:0]  irq_en_o,
  output logic        soft_rst_o
);

  logic [31:0]        arg_q;
  logic [5:0]         cmd_index_q;
  logic [1:0]         cmd_type_q;
  logic [7:0]         clk_div_q;
  logic [6:0]         irq_en_q;
  logic [CreditW-1:0] credits_q;
  logic               push_q;
  logic               soft_rst_q;
  logic               wr_en;
  logic               cmd_accept;
  logic               queue_full;

  assign wr_en      = reg_valid_i && reg_write_i;
  assign queue_full = (credits_q == '0);
  assign cmd_accept = wr_en && (reg_addr_i == RegCmd) && !queue_full;

  // write-one-to-clear strobes go straight to the collector
  assign status_clr_o = (wr_en && reg_addr_i == RegStatus) ? reg_wdata_i[6:0] : 7'd0;

  always_ff @(posedge clk_i) begin
    if (wr_en && reg_addr_i == RegArg) begin
      arg_q <= reg_wdata_i;
    end
    if (cmd_accept) begin
      cmd_index_q <= reg_wdata_i[5:0];
      cmd_type_q  <= reg_wdata_i[9:8];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      clk_div_q  <= 8'd0;
      irq_en_q   <= 7'd0;
      soft_rst_q <= 1'b0;
    end else begin
      soft_rst_q <= wr_en && (reg_addr_i == RegSoftReset) && reg_wdata_i[0];
      if (wr_en && reg_addr_i == RegClkDiv) begin
        clk_div_q <= reg_wdata_i[7:0];
      end
      if (wr_en && reg_addr_i == RegIrqEn) begin
        irq_en_q <= reg_wdata_i[6:0];
      end
    end
  end

  // credits track free slots in the engine queue
  always_ff @(posedge clk_i) begin
    if (rst_i || soft_rst_q) begin
      credits_q <= CreditW'(CmdQueueDepth);
      push_q    <= 1'b0;
    end else begin
      push_q <= cmd_accept;
      case ({cmd_accept, cmd_credit_i})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: credits_q <= credits_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_valid_i && !reg_write_i) begin
      case (reg_addr_i)
        RegArg:    reg_rdata_o <= arg_q;
        RegCmd:    reg_rdata_o <= {22'd0, cmd_type_q, 2'd0, cmd_index_q};
        RegResp:   reg_rdata_o <= resp_arg_i;
        RegStatus: reg_rdata_o <= {23'd0, queue_full, status_i};
        RegClkDiv: reg_rdata_o <= {24'd0, clk_div_q};
        RegIrqEn:  reg_rdata_o <= {25'd0, irq_en_q};
        default:   reg_rdata_o <= 32'd0;
      endcase
    end
  end

  assign cmd_push_o      = push_q;
  assign cmd_arg_o       = arg_q;
  assign cmd_index_o     = cmd_index_q;
  assign cmd_resp_type_o = cmd_type_q;
  assign clk_div_o       = clk_div_q;
  assign irq_en_o        = irq_en_q;
  assign soft_rst_o      = soft_rst_q;

endmodule

// ==== rtl/sdhc_resp_collect.sv ====
/* response checks and sticky status; a set in the same cycle wins over a clear
   R3 responses skip the crc and index checks */
`timescale 1ns/1ns
module sdhc_resp_collect
  import sdhc_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        soft_rst_i,
  input  logic        resp_valid_i,
  input  logic        resp_timeout_i,
  input  logic [1:0]  resp_type_i,
  input  logic [5:0]  exp_index_i,
  input  logic [5:0]  resp_index_i,
  input  logic [31:0] resp_arg_i,
  input  logic [6:0]  resp_crc_i,
  input  logic        resp_end_i,
  input  logic        card_inserted_i,
  input  logic [6:0]  status_clr_i,
  input  logic [6:0]  irq_en_i,
  output logic [7:0]  status_o,
  output logic [31:0] resp_arg_o,
  output logic        irq_o
);

  sdhc_resp_u  resp_u;
  logic [39:0] crc_bits;
  logic [6:0]  crc_calc;
  logic [6:0]  set_bits;
  logic [6:0]  status_q;
  logic [31:0] resp_arg_q;

  assign resp_u = resp_arg_i;

  // start and direction bits of a response are both 0
  assign crc_bits = {2'b00, resp_index_i, resp_arg_i};

  always_comb begin
    crc_calc = 7'd0;
    for (int i = 39; i >= 0; i--) begin
      crc_calc = crc7_next(crc_calc, crc_bits[i]);
    end
  end

  always_comb begin
    set_bits = 7'd0;
    if (resp_valid_i) begin
      set_bits[StDone] = 1'b1;
      if (resp_timeout_i) begin
        set_bits[StTimeout] = 1'b1;
      end else if (resp_type_i == RespR1) begin
        set_bits[StCrcErr]   = (resp_crc_i != crc_calc);
        set_bits[StIndexErr] = (resp_index_i != exp_index_i);
        set_bits[StEndErr]   = !resp_end_i;
        set_bits[StCardErr]  = |resp_u.r1.err;
      end else if (resp_type_i == RespR3) begin
        set_bits[StEndErr] = !resp_end_i;
        set_bits[StBusy]   = !resp_u.r3.busy_n;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || soft_rst_i) begin
      status_q <= 7'd0;
    end else begin
      status_q <= (status_q & ~status_clr_i) | set_bits;
    end
  end

  // only a received response updates RESP
  always_ff @(posedge clk_i) begin
    if (resp_valid_i && !resp_timeout_i && resp_type_i != RespNone) begin
      resp_arg_q <= resp_arg_i;
    end
  end

  assign status_o   = {card_inserted_i, status_q};
  assign resp_arg_o = resp_arg_q;
  assign irq_o      = |(status_q & irq_en_i);

endmodule

// ==== rtl/sdhc_top.sv ====
/* SD host, command line only; sd_cmd_o is valid while sd_cmd_en_o is high
   sd_cmd_i needs an external pull-up so the idle line reads 1 */
`timescale 1ns/1ns
module sdhc_top (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        reg_valid_i,
  input  logic        reg_write_i,
  input  logic [3:0]  reg_addr_i,
  input  logic [31:0] reg_wdata_i,
  output logic [31:0] reg_rdata_o,
  output logic        sd_clk_o,
  output logic        sd_cmd_o,
  output logic        sd_cmd_en_o,
  input  logic        sd_cmd_i,
  input  logic        sd_cd_ni,
  output logic        irq_o
);

  logic [7:0]  status;
  logic [31:0] resp_reg;
  logic [6:0]  status_clr;
  logic        cmd_push;
  logic [31:0] cmd_arg;
  logic [5:0]  cmd_index;
  logic [1:0]  cmd_resp_type;
  logic        cmd_credit;
  logic [7:0]  clk_div;
  logic [6:0]  irq_en;
  logic        soft_rst;
  logic        sd_clk_rise;
  logic        sd_clk_fall;
  logic        resp_valid;
  logic        resp_timeout;
  logic [1:0]  resp_type;
  logic [5:0]  exp_index;
  logic [5:0]  resp_index;
  logic [31:0] resp_arg;
  logic [6:0]  resp_crc;
  logic        resp_end;
  logic        card_inserted;

  sdhc_reg_decode i_reg_decode (
    .clk_i,
    .rst_i,
    .reg_valid_i,
    .reg_write_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rdata_o,
    .status_i        (status),
    .resp_arg_i      (resp_reg),
    .status_clr_o    (status_clr),
    .cmd_push_o      (cmd_push),
    .cmd_arg_o       (cmd_arg),
    .cmd_index_o     (cmd_index),
    .cmd_resp_type_o (cmd_resp_type),
    .cmd_credit_i    (cmd_credit),
    .clk_div_o       (clk_div),
    .irq_en_o        (irq_en),
    .soft_rst_o      (soft_rst)
  );

  sdhc_clk_gen i_clk_gen (
    .clk_i,
    .rst_i,
    .clk_div_i     (clk_div),
    .sd_clk_o,
    .sd_clk_rise_o (sd_clk_rise),
    .sd_clk_fall_o (sd_clk_fall)
  );

  sdhc_cmd_engine i_cmd_engine (
    .clk_i,
    .rst_i,
    .soft_rst_i      (soft_rst),
    .sd_clk_rise_i   (sd_clk_rise),
    .sd_clk_fall_i   (sd_clk_fall),
    .cmd_push_i      (cmd_push),
    .cmd_arg_i       (cmd_arg),
    .cmd_index_i     (cmd_index),
    .cmd_resp_type_i (cmd_resp_type),
    .cmd_credit_o    (cmd_credit),
    .sd_cmd_o,
    .sd_cmd_en_o,
    .sd_cmd_i,
    .resp_valid_o    (resp_valid),
    .resp_timeout_o  (resp_timeout),
    .resp_type_o     (resp_type),
    .exp_index_o     (exp_index),
    .resp_index_o    (resp_index),
    .resp_arg_o      (resp_arg),
    .resp_crc_o      (resp_crc),
    .resp_end_o      (resp_end)
  );

  sdhc_resp_collect i_resp_collect (
    .clk_i,
    .rst_i,
    .soft_rst_i      (soft_rst),
    .resp_valid_i    (resp_valid),
    .resp_timeout_i  (resp_timeout),
    .resp_type_i     (resp_type),
    .exp_index_i     (exp_index),
    .resp_index_i    (resp_index),
    .resp_arg_i      (resp_arg),
    .resp_crc_i      (resp_crc),
    .resp_end_i      (resp_end),
    .card_inserted_i (card_inserted),
    .status_clr_i    (status_clr),
    .irq_en_i        (irq_en),
    .status_o        (status),
    .resp_arg_o      (resp_reg),
    .irq_o
  );

  sdhc_card_detect i_card_detect (
    .clk_i,
    .rst_i,
    .sd_cd_ni,
    .card_inserted_o (card_inserted)
  );

endmodule

// ==== verification/sdhc_card_model.sv ====
/* behavioural SD card, command line only; answers each frame two SD clocks after its end bit
   fault inputs must be stable before the end bit of the frame they apply to */
`timescale 1ns/1ns
module sdhc_card_model
  import sdhc_pkg::*;
(
  input  logic        sd_clk_i,
  input  logic        cmd_i,
  input  logic        cmd_en_i,
  input  logic        silent_i,
  input  logic        bad_crc_i,
  input  logic        bad_index_i,
  input  logic        r3_i,
  input  logic [31:0] resp_arg_i,
  output logic        cmd_o,
  output logic [47:0] frame_o,
  output logic [31:0] frame_cnt_o
);

  logic [47:0] rx_frame;
  logic [47:0] tx_frame;
  logic [39:0] body;
  logic [6:0]  crc;
  logic [5:0]  idx;

  // polynomial x^7 + x^3 + 1, MSB first
  function automatic logic [6:0] frame_crc(logic [39:0] bits);
    logic [6:0] c;
    logic       fb;
    c = 7'd0;
    for (int i = 39; i >= 0; i--) begin
      fb = c[6] ^ bits[i];
      c  = {c[5:0], 1'b0};
      if (fb) begin
        c = c ^ 7'h09;
      end
    end
    return c;
  endfunction

  initial begin
    cmd_o       = 1'b1;
    frame_o     = '0;
    frame_cnt_o = '0;
    forever begin
      @(posedge sd_clk_i);
      // start bit seen while the host drives the line
      if (cmd_en_i && !cmd_i) begin
        rx_frame = '0;
        for (int i = 1; i < FrameBits; i++) begin
          @(posedge sd_clk_i);
          rx_frame[FrameBits-1-i] = cmd_i;
        end
        frame_o     = rx_frame;
        frame_cnt_o = frame_cnt_o + 1;
        if (!silent_i) begin
          if (r3_i) begin
            tx_frame = {2'b00, 6'h3f, resp_arg_i, 7'h7f, 1'b1};
          end else begin
            idx  = bad_index_i ? ~rx_frame[45:40] : rx_frame[45:40];
            body = {2'b00, idx, resp_arg_i};
            crc  = frame_crc(body);
            if (bad_crc_i) begin
              crc = crc ^ 7'h01;
            end
            tx_frame = {body, crc, 1'b1};
          end
          repeat (2) @(posedge sd_clk_i);
          // change on the falling edge, the host samples on the rising edge
          for (int i = FrameBits - 1; i >= 0; i--) begin
            @(negedge sd_clk_i);
            cmd_o = tx_frame[i];
          end
          @(negedge sd_clk_i);
          cmd_o = 1'b1;
        end
      end
    end
  end

endmodule

// ==== verification/sdhc_tb.sv ====
/* testbench for the SD command-line host; the card model answers every frame
   register accesses are driven on the rising edge and sampled on the falling edge */
`timescale 1ns/1ns
module sdhc_tb
  import sdhc_pkg::*;
;

  localparam int ClkPeriodNs   = 10;
  localparam int MaxClkDiv     = 2;
  localparam int SdPeriodClks  = 2 * (MaxClkDiv + 1);
  localparam int CmdSdClks     = 2 * FrameBits + RespTimeoutClks;
  localparam int NumCmds       = 12;
  localparam int IrqWaitCycles = (CmdSdClks + 16) * SdPeriodClks;
  localparam int WatchdogNs    = NumCmds * CmdSdClks * SdPeriodClks * ClkPeriodNs + 20000;

  logic        clk_i;
  logic        rst_i;
  logic        reg_valid_i;
  logic        reg_write_i;
  logic [3:0]  reg_addr_i;
  logic [31:0] reg_wdata_i;
  logic [31:0] reg_rdata_o;
  logic        sd_clk_o;
  logic        sd_cmd_o;
  logic        sd_cmd_en_o;
  logic        sd_cmd_i;
  logic        sd_cd_ni;
  logic        irq_o;

  logic        card_silent;
  logic        card_bad_crc;
  logic        card_bad_index;
  logic        card_r3;
  logic [31:0] card_arg;
  logic [47:0] frame;
  logic [31:0] frame_cnt;

  logic [47:0] exp_frames[$];
  string       test_name;
  integer      seed = 47;
  int          errors = 0;
  int          checks = 0;
  int          en_clks = 0;

  sdhc_top i_sdhc_top (
    .clk_i,
    .rst_i,
    .reg_valid_i,
    .reg_write_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rdata_o,
    .sd_clk_o,
    .sd_cmd_o,
    .sd_cmd_en_o,
    .sd_cmd_i,
    .sd_cd_ni,
    .irq_o
  );

  sdhc_card_model i_card (
    .sd_clk_i    (sd_clk_o),
    .cmd_i       (sd_cmd_o),
    .cmd_en_i    (sd_cmd_en_o),
    .silent_i    (card_silent),
    .bad_crc_i   (card_bad_crc),
    .bad_index_i (card_bad_index),
    .r3_i        (card_r3),
    .resp_arg_i  (card_arg),
    .cmd_o       (sd_cmd_i),
    .frame_o     (frame),
    .frame_cnt_o (frame_cnt)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriodNs / 2) clk_i = !clk_i;
  end

  // serial crc7, x^7 + x^3 + 1, over the first 40 frame bits
  function automatic logic [6:0] crc7_ref(logic [39:0] bits);
    logic [6:0] crc;
    logic       fb;
    crc = 7'd0;
    for (int i = 39; i >= 0; i--) begin
      fb  = crc[6] ^ bits[i];
      crc = {crc[5:0], 1'b0};
      if (fb) begin
        crc = crc ^ 7'h09;
      end
    end
    return crc;
  endfunction

  function automatic logic [47:0] frame_ref(logic [5:0] index, logic [31:0] arg);
    logic [39:0] body;
    body = {2'b01, index, arg};
    return {body, crc7_ref(body), 1'b1};
  endfunction

  function automatic logic [6:0] status_ref(logic [1:0] rtype, logic silent, logic bad_crc,
                                            logic bad_index, logic [31:0] arg);
    logic [6:0] st;
    st = 7'd0;
    st[StDone] = 1'b1;
    if (rtype != RespNone) begin
      if (silent) begin
        st[StTimeout] = 1'b1;
      end else if (rtype == RespR1) begin
        st[StCrcErr]   = bad_crc;
        st[StIndexErr] = bad_index;
        st[StCardErr]  = |arg[31:19];
      end else begin
        st[StBusy] = !arg[31];
      end
    end
    return st;
  endfunction

  task automatic check_val(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("error: %s %s expected 0x%0h actual 0x%0h", test_name, what, expected, actual);
    end
  endtask

  task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    reg_valid_i <= 1'b1;
    reg_write_i <= 1'b1;
    reg_addr_i  <= addr;
    reg_wdata_i <= data;
    @(posedge clk_i);
    reg_valid_i <= 1'b0;
    reg_write_i <= 1'b0;
  endtask

  task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
    @(posedge clk_i);
    reg_valid_i <= 1'b1;
    reg_write_i <= 1'b0;
    reg_addr_i  <= addr;
    @(posedge clk_i);
    reg_valid_i <= 1'b0;
    @(negedge clk_i);
    data = reg_rdata_o;
  endtask

  task automatic set_card(input logic silent, input logic bad_crc, input logic bad_index,
                          input logic r3, input logic [31:0] arg);
    @(posedge clk_i);
    card_silent    <= silent;
    card_bad_crc   <= bad_crc;
    card_bad_index <= bad_index;
    card_r3        <= r3;
    card_arg       <= arg;
  endtask

  task automatic drive_cd(input logic value);
    @(posedge clk_i);
    sd_cd_ni <= value;
  endtask

  task automatic issue_cmd(input logic [5:0] index, input logic [1:0] rtype,
                           input logic [31:0] arg, input logic expect_frame);
    reg_write(RegArg, arg);
    reg_write(RegCmd, {22'd0, rtype, 2'd0, index});
    if (expect_frame) begin
      exp_frames.push_back(frame_ref(index, arg));
    end
  endtask

  task automatic wait_irq();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!irq_o && cycles < IrqWaitCycles) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!irq_o) begin
      errors++;
      $display("error: %s timed out waiting for irq_o", test_name);
    end
  endtask

  task automatic clear_status();
    logic [31:0] rdata;
    reg_write(RegStatus, 32'h7f);
    @(negedge clk_i);
    check_val("irq_o after clear", 0, irq_o);
    reg_read(RegStatus, rdata);
    check_val("status after clear", 0, rdata[6:0]);
  endtask

  task automatic resp_test(input logic [5:0] index, input logic [1:0] rtype,
                           input logic [31:0] cmd_arg, input logic silent,
                           input logic bad_crc, input logic bad_index,
                           input logic [31:0] resp_arg);
    logic [31:0] rdata;
    set_card(silent, bad_crc, bad_index, rtype == RespR3, resp_arg);
    issue_cmd(index, rtype, cmd_arg, 1'b1);
    wait_irq();
    if (rtype != RespNone && !silent) begin
      reg_read(RegResp, rdata);
      check_val("resp", resp_arg, rdata);
    end
    reg_read(RegStatus, rdata);
    check_val("status", {25'd0, status_ref(rtype, silent, bad_crc, bad_index, resp_arg)},
              rdata);
    clear_status();
  endtask

  // every frame the card records is compared with the oldest expected frame
  initial begin : frame_compare
    forever begin
      @(frame_cnt);
      // frame and count have both settled by the falling edge
      @(negedge clk_i);
      if (exp_frames.size() == 0) begin
        errors++;
        $display("error: %s card saw frame 0x%h with no command pending", test_name, frame);
      end else begin
        check_val("frame", exp_frames.pop_front(), frame);
      end
    end
  end

  // SD clocks with the command driver enabled, 48 per frame
  initial begin : enable_count
    forever begin
      @(posedge sd_clk_o);
      if (sd_cmd_en_o) begin
        en_clks++;
      end
    end
  end

  initial begin : watchdog
    #(WatchdogNs);
    $display("watchdog expired after %0d ns, a test did not finish", WatchdogNs);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] rdata;
    logic [31:0] rnd;
    logic [31:0] arg;
    rst_i          = 1'b1;
    reg_valid_i    = 1'b0;
    reg_write_i    = 1'b0;
    reg_addr_i     = 4'd0;
    reg_wdata_i    = 32'd0;
    sd_cd_ni       = 1'b1;
    card_silent    = 1'b0;
    card_bad_crc   = 1'b0;
    card_bad_index = 1'b0;
    card_r3        = 1'b0;
    card_arg       = 32'd0;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;

    // CMD0 and CMD8 crc values from the SD specification
    test_name = "crc7_known";
    check_val("cmd0 crc", 7'h4a, crc7_ref({2'b01, 6'd0, 32'd0}));
    check_val("cmd8 crc", 7'h43, crc7_ref({2'b01, 6'd8, 32'h1aa}));

    test_name = "reset_state";
    @(negedge clk_i);
    check_val("sd_cmd_o", 1, sd_cmd_o);
    check_val("sd_cmd_en_o", 0, sd_cmd_en_o);
    check_val("irq_o", 0, irq_o);
    reg_read(RegStatus, rdata);
    check_val("status", 0, rdata);

    reg_write(RegClkDiv, 32'd1);
    reg_write(RegIrqEn, 32'h7f);

    test_name = "r1_random";
    rnd = $random(seed);
    arg = $random(seed);
    resp_test(rnd[5:0], RespR1, arg, 1'b0, 1'b0, 1'b0, $random(seed) & 32'h0007_ffff);
    test_name = "r1_bad_crc";
    resp_test(6'd13, RespR1, 32'h1234_0000, 1'b0, 1'b1, 1'b0, 32'h0000_0900);
    test_name = "r1_bad_index";
    resp_test(6'd55, RespR1, 32'h0000_0001, 1'b0, 1'b0, 1'b1, 32'h0000_0120);
    test_name = "r1_card_error";
    resp_test(6'd17, RespR1, 32'h0000_0200, 1'b0, 1'b0, 1'b0, 32'h8000_0900);
    test_name = "r3_busy";
    resp_test(6'd41, RespR3, 32'h40ff_8000, 1'b0, 1'b0, 1'b0, 32'h00ff_8000);
    test_name = "r1_timeout";
    resp_test(6'd2, RespR1, 32'd0, 1'b1, 1'b0, 1'b0, 32'd0);
    test_name = "no_response";
    resp_test(6'd0, RespNone, 32'd0, 1'b1, 1'b0, 1'b0, 32'd0);

    // one frame in flight and two queued, the fourth write finds no credit
    test_name = "queue_full";
    reg_write(RegClkDiv, MaxClkDiv);
    set_card(1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_0900);
    issue_cmd(6'd17, RespR1, 32'h0000_1000, 1'b1);
    issue_cmd(6'd18, RespR1, 32'h0000_2000, 1'b1);
    issue_cmd(6'd24, RespR1, 32'h0000_3000, 1'b1);
    reg_read(RegStatus, rdata);
    check_val("queue full", 1, rdata[StQueueFull]);
    issue_cmd(6'd25, RespR1, 32'hdead_beef, 1'b0);
    repeat (3) begin
      wait_irq();
      reg_read(RegStatus, rdata);
      check_val("status", 32'h001, rdata);
      clear_status();
    end

    test_name = "card_detect";
    drive_cd(1'b0);
    repeat (5) @(posedge clk_i);
    reg_read(RegStatus, rdata);
    check_val("inserted during glitch", 0, rdata[StInserted]);
    drive_cd(1'b1);
    repeat (40) @(posedge clk_i);
    reg_read(RegStatus, rdata);
    check_val("inserted after glitch", 0, rdata[StInserted]);
    drive_cd(1'b0);
    repeat (8) @(posedge clk_i);
    reg_read(RegStatus, rdata);
    check_val("inserted while settling", 0, rdata[StInserted]);
    repeat (30) @(posedge clk_i);
    reg_read(RegStatus, rdata);
    check_val("inserted when stable", 1, rdata[StInserted]);

    test_name = "soft_reset";
    set_card(1'b1, 1'b0, 1'b0, 1'b0, 32'd0);
    issue_cmd(6'd0, RespNone, 32'd0, 1'b1);
    wait_irq();
    reg_write(RegSoftReset, 32'd1);
    @(posedge clk_i);
    @(negedge clk_i);
    check_val("irq_o", 0, irq_o);
    reg_read(RegStatus, rdata);
    check_val("status", 32'h080, rdata);
    reg_read(RegSoftReset, rdata);
    check_val("soft reset reg", 0, rdata);

    // room for a dropped command to show up if it was wrongly queued
    test_name = "final";
    repeat (CmdSdClks * SdPeriodClks) @(posedge clk_i);
    check_val("pending frames", 0, exp_frames.size());
    check_val("cmd enable clocks", FrameBits * frame_cnt, en_clks);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
rtl/sdhc_pkg.sv
rtl/sdhc_card_detect.sv
rtl/sdhc_clk_gen.sv
rtl/sdhc_cmd_engine.sv
rtl/sdhc_reg_decode.sv
rtl/sdhc_resp_collect.sv
rtl/sdhc_top.sv
verification/sdhc_card_model.sv
verification/sdhc_tb.sv
